// File: tests/loadMissStim.txt
# Commands with hex arguments, one per line
# fill <line>  beats <n>  load <tag> <addr> <sqN> <ext>  branch <sqN>  wait <total>  full <lvl>
fill 40
# Loads waiting on words not fetched yet
load 1 2010 05 0
load 2 2040 06 0
beats 5
wait 1
beats 3
# Words already in the buffer
load 3 2008 07 0
load 4 201c 08 0
wait 3
# Queue fills up with waiting loads
load 5 2050 09 0
load 6 2060 0a 1
load 7 2070 0b 0
full 1
beats 9
full 0
wait 4
# Branch removes younger non-external loads
load 8 2074 0c 0
branch 09
load 9 2048 03 0
beats f
wait 7
# Second line, branch sqN wraps around
fill 41
load a 2084 7e 0
load b 2090 02 0
load c 20a0 05 1
branch 7f
beats 20
wait 9
load d 20fc 10 0
load e 2080 11 1
wait b

// File: src.f
verilog/loadMissPkg.sv
verilog/loadMissQueue.sv
verilog/lineFillUnit.sv
verilog/loadResultStage.sv
verilog/loadMissTop.sv
tests/loadMissTb.sv

// File: tests/loadMissTb.sv
`timescale 1ns/1ps
`default_nettype none

module loadMissTb;

    localparam int queueSize = 4;
    localparam int lineSizeExp = 7;
    localparam int wordCount = 2 ** (lineSizeExp - 2);
    localparam int timeoutCycles = 400;

    logic clk;
    logic rst;
    logic enqueue;
    loadMissPkg::LdUop newLoad;
    loadMissPkg::BranchProv branch;
    logic fillStart;
    logic [31-lineSizeExp:0] fillLine;
    logic memValid;
    logic [31:0] memData;
    logic full;
    logic fillActive;
    loadMissPkg::LoadResult result;

    // Reference copy of the line being filled
    logic [31:0] lineModel [wordCount];
    int beatsSent;
    logic [31:0] lcgState;

    // Outstanding loads by tag
    bit pendValid [16];
    logic [31:0] pendAddr [16];
    logic [6:0] pendSqN [16];
    bit pendExt [16];
    int pendCount;
    int resultCount;

    // Stimulus file reading
    int fd;
    int code;
    logic [8*96-1:0] textLine;
    logic [8*8-1:0] cmd;
    logic [31:0] arg0, arg1, arg2, arg3;

    loadMissTop #(
        .queueSize(queueSize),
        .lineSizeExp(lineSizeExp)
    ) dut_i (
        .clk(clk),
        .rst(rst),
        .enqueue(enqueue),
        .newLoad(newLoad),
        .branch(branch),
        .fillStart(fillStart),
        .fillLine(fillLine),
        .memValid(memValid),
        .memData(memData),
        .full(full),
        .fillActive(fillActive),
        .result(result)
    );

    always #50 clk = ~clk;

    task automatic abortRun();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic valueError(input string sigName, input logic [31:0] expected,
                              input logic [31:0] actual);
        $display("[ERROR] %s: expected 0x%08h, got 0x%08h", sigName, expected, actual);
        abortRun();
    endtask

    task automatic plainError(input string what);
        $display("%s", what);
        abortRun();
    endtask

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Younger non-external loads die on a taken branch
    function automatic logic isFlushed(input logic [6:0] ldSqN, input logic ext,
                                       input logic [6:0] brSqN);
        logic signed [6:0] age;
        age = ldSqN - brSqN;
        return !ext && (age > 0);
    endfunction

    // Results sampled mid-cycle while they are stable
    always @(negedge clk) begin : resultMonitor
        logic [lineSizeExp-3:0] wordIdx;
        if (!rst && result.valid) begin
            assert (pendValid[result.loadId])
                else plainError($sformatf("result for tag %0h, which is not outstanding",
                    result.loadId));
            wordIdx = pendAddr[result.loadId][lineSizeExp-1:2];
            assert (beatsSent > wordIdx)
                else plainError($sformatf("tag %0h returned before its word arrived",
                    result.loadId));
            assert (result.data == lineModel[wordIdx])
                else valueError("result.data", lineModel[wordIdx], result.data);
            pendValid[result.loadId] = 1'b0;
            pendCount--;
            resultCount++;
        end
    end

    task automatic startFill(input logic [31:0] line);
        @(posedge clk);
        fillStart <= 1'b1;
        fillLine <= line[31-lineSizeExp:0];
        @(posedge clk);
        fillStart <= 1'b0;
        beatsSent = 0;
        @(negedge clk);
        assert (fillActive == 1'b1) else valueError("fillActive", 32'h1, fillActive);
    endtask

    task automatic sendBeats(input int count);
        logic [31:0] word;
        logic stillFilling;
        for (int i = 0; i < count; i++) begin
            word = nextRandom();
            @(posedge clk);
            memValid <= 1'b1;
            memData <= word;
            lineModel[beatsSent] = word;
            beatsSent++;
        end
        @(posedge clk);
        memValid <= 1'b0;
        // Fill drops back to idle right after the last word
        stillFilling = (beatsSent < wordCount);
        @(negedge clk);
        assert (fillActive == stillFilling)
            else valueError("fillActive", stillFilling, fillActive);
    endtask

    task automatic enqueueLoad(input logic [3:0] tag, input logic [31:0] addr,
                               input logic [6:0] sqN, input logic ext);
        @(negedge clk);
        assert (!full) else plainError("stimulus tried to enqueue into a full queue");
        assert (!pendValid[tag])
            else plainError($sformatf("stimulus reuses outstanding tag %0h", tag));
        @(posedge clk);
        enqueue <= 1'b1;
        newLoad.valid <= 1'b1;
        newLoad.external <= ext;
        newLoad.sqN <= sqN;
        newLoad.loadId <= tag;
        newLoad.addr <= addr;
        pendValid[tag] = 1'b1;
        pendAddr[tag] = addr;
        pendSqN[tag] = sqN;
        pendExt[tag] = ext;
        pendCount++;
        @(posedge clk);
        enqueue <= 1'b0;
        newLoad.valid <= 1'b0;
    endtask

    task automatic takeBranch(input logic [6:0] sqN);
        @(posedge clk);
        branch.taken <= 1'b1;
        branch.sqN <= sqN;
        for (int t = 0; t < 16; t++) begin
            if (pendValid[t] && isFlushed(pendSqN[t], pendExt[t], sqN)) begin
                pendValid[t] = 1'b0;
                pendCount--;
            end
        end
        @(posedge clk);
        branch.taken <= 1'b0;
    endtask

    task automatic waitResults(input int total);
        int cycles;
        cycles = 0;
        while (resultCount < total && cycles < timeoutCycles) begin
            @(posedge clk);
            cycles++;
        end
        assert (resultCount >= total)
            else plainError($sformatf("timed out with %0d of %0d results", resultCount, total));
    endtask

    task automatic waitFull(input logic level);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (full !== level && cycles < timeoutCycles) begin
            @(negedge clk);
            cycles++;
        end
        assert (full === level) else valueError("full", level, full);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        enqueue = 1'b0;
        newLoad = '0;
        branch = '0;
        fillStart = 1'b0;
        fillLine = '0;
        memValid = 1'b0;
        memData = '0;
        lcgState = 32'd61;
        beatsSent = 0;
        pendCount = 0;
        resultCount = 0;
        for (int t = 0; t < 16; t++) begin
            pendValid[t] = 1'b0;
        end

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (full == 1'b0) else valueError("full", 32'h0, full);
        assert (fillActive == 1'b0) else valueError("fillActive", 32'h0, fillActive);
        assert (result.valid == 1'b0) else valueError("result.valid", 32'h0, result.valid);

        fd = $fopen("tests/loadMissStim.txt", "r");
        assert (fd != 0) else plainError("cannot open tests/loadMissStim.txt");

        code = $fgets(textLine, fd);
        while (code != 0) begin
            if ($sscanf(textLine, "%s", cmd) >= 1 && cmd != "#") begin
                code = $sscanf(textLine, "%s %h %h %h %h", cmd, arg0, arg1, arg2, arg3);
                if (cmd == "fill") begin
                    startFill(arg0);
                end else if (cmd == "beats") begin
                    sendBeats(arg0);
                end else if (cmd == "load") begin
                    enqueueLoad(arg0[3:0], arg1, arg2[6:0], arg3[0]);
                end else if (cmd == "branch") begin
                    takeBranch(arg0[6:0]);
                end else if (cmd == "wait") begin
                    waitResults(arg0);
                end else if (cmd == "full") begin
                    waitFull(arg0[0]);
                end else begin
                    plainError("unknown command in stimulus file");
                end
            end
            code = $fgets(textLine, fd);
        end
        $fclose(fd);

        // Let any stray result show up before the final count
        repeat (10) @(posedge clk);
        if (pendCount == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            plainError($sformatf("%0d loads never returned", pendCount));
        end
    end

endmodule

`default_nettype wire

// File: verilog/loadMissTop.sv
`timescale 1ns/1ps
`default_nettype none

module loadMissTop #(
    parameter int queueSize = 4,
    parameter int lineSizeExp = 7
) (
    input wire clk,
    input wire rst,

    input wire enqueue,
    input wire loadMissPkg::LdUop newLoad,
    input wire loadMissPkg::BranchProv branch,

    input wire fillStart,
    input wire [31-lineSizeExp:0] fillLine,
    input wire memValid,
    input wire [31:0] memData,

    output logic full,
    output logic fillActive,
    output loadMissPkg::LoadResult result
);

    // Fill progress seen by the queue
    logic loadActive;
    logic [lineSizeExp-2:0] loadProgress;
    logic [31-lineSizeExp:0] loadLine;

    // Buffer read port used by the result stage
    logic [lineSizeExp-3:0] readIndex;
    logic [31:0] readData;

    loadMissPkg::LdUop outLd;
    logic dequeue;

    loadMissQueue #(
        .queueSize(queueSize),
        .lineSizeExp(lineSizeExp)
    ) queue_i (
        .clk(clk),
        .rst(rst),
        .branch(branch),
        .enqueue(enqueue),
        .newLoad(newLoad),
        .loadActive(loadActive),
        .loadProgress(loadProgress),
        .loadLine(loadLine),
        .full(full),
        .outLd(outLd),
        .dequeue(dequeue)
    );

    lineFillUnit #(
        .lineSizeExp(lineSizeExp)
    ) fill_i (
        .clk(clk),
        .rst(rst),
        .fillStart(fillStart),
        .fillLine(fillLine),
        .memValid(memValid),
        .memData(memData),
        .fillActive(fillActive),
        .loadActive(loadActive),
        .loadProgress(loadProgress),
        .loadLine(loadLine),
        .readIndex(readIndex),
        .readData(readData)
    );

    loadResultStage #(
        .lineSizeExp(lineSizeExp)
    ) result_i (
        .clk(clk),
        .rst(rst),
        .outLd(outLd),
        .dequeue(dequeue),
        .readIndex(readIndex),
        .readData(readData),
        .result(result)
    );

endmodule

`default_nettype wire

// File: verilog/loadResultStage.sv
`timescale 1ns/1ps
`default_nettype none

module loadResultStage #(
    parameter int lineSizeExp = 7
) (
    input wire clk,
    input wire rst,

    input wire loadMissPkg::LdUop outLd,
    output logic dequeue,

    output logic [lineSizeExp-3:0] readIndex,
    input wire [31:0] readData,

    output loadMissPkg::LoadResult result
);

    // Never stalls, so anything offered is taken right away
    assign dequeue = outLd.valid;

    // Word within the line, byte offset dropped
    assign readIndex = outLd.addr[lineSizeExp-1:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= outLd.valid;
        end
    end

    // Tag and data only change with a new load
    always_ff @(posedge clk) begin
        if (outLd.valid) begin
            result.loadId <= outLd.loadId;
            result.data <= readData;
        end
    end

endmodule

`default_nettype wire

// File: verilog/lineFillUnit.sv
`timescale 1ns/1ps
`default_nettype none

module lineFillUnit #(
    parameter int lineSizeExp = 7
) (
    input wire clk,
    input wire rst,

    input wire fillStart,
    input wire [31-lineSizeExp:0] fillLine,

    input wire memValid,
    input wire [31:0] memData,

    output logic fillActive,
    output logic loadActive,
    output logic [lineSizeExp-2:0] loadProgress,
    output logic [31-lineSizeExp:0] loadLine,

    input wire [lineSizeExp-3:0] readIndex,
    output logic [31:0] readData
);

    localparam int wordCount = 2 ** (lineSizeExp - 2);
    localparam logic [lineSizeExp-2:0] lastWord = (lineSizeExp-1)'(wordCount - 1);

    loadMissPkg::FillState state;

    // One 32-bit word per memory beat
    logic [31:0] lineBuf [wordCount];

    logic beatTaken;

    // A new fill start wins over a beat in the same cycle
    assign beatTaken = (state == loadMissPkg::FILLING) && memValid && !fillStart;

    assign fillActive = (state == loadMissPkg::FILLING);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= loadMissPkg::IDLE;
            loadProgress <= '0;
            loadActive <= 1'b0;
        end else if (fillStart) begin
            state <= loadMissPkg::FILLING;
            loadProgress <= '0;
            // Stays up after the fill so the line remains readable
            loadActive <= 1'b1;
        end else begin
            case (state)
                loadMissPkg::FILLING: begin
                    if (memValid) begin
                        loadProgress <= loadProgress + 1'b1;
                        if (loadProgress == lastWord) begin
                            state <= loadMissPkg::IDLE;
                        end
                    end
                end
                default: begin
                    state <= loadMissPkg::IDLE;
                end
            endcase
        end
    end

    // Line address and buffered data
    always_ff @(posedge clk) begin
        if (fillStart) begin
            loadLine <= fillLine;
        end
        if (beatTaken) begin
            lineBuf[loadProgress[lineSizeExp-3:0]] <= memData;
        end
    end

    assign readData = lineBuf[readIndex];

    // Memory only sends beats for a fill in progress
    assert property (@(posedge clk) disable iff (rst)
        memValid |-> state == loadMissPkg::FILLING)
        else $error("memory beat with no fill in progress");

endmodule

`default_nettype wire

// File: verilog/loadMissQueue.sv
`timescale 1ns/1ps
`default_nettype none

module loadMissQueue #(
    parameter int queueSize = 4,
    parameter int lineSizeExp = 7
) (
    input wire clk,
    input wire rst,

    input wire loadMissPkg::BranchProv branch,

    input wire enqueue,
    input wire loadMissPkg::LdUop newLoad,

    input wire loadActive,
    input wire [lineSizeExp-2:0] loadProgress,
    input wire [31-lineSizeExp:0] loadLine,

    output logic full,
    output loadMissPkg::LdUop outLd,
    input wire dequeue
);

    localparam int idxW = (queueSize > 1) ? $clog2(queueSize) : 1;

    typedef struct packed {
        logic ready;
        loadMissPkg::LdUop ld;
    } QueueEntry;

    // Unordered entries where any slot may hold any load
    QueueEntry entries [queueSize];

    logic [queueSize-1:0] keep;
    logic [queueSize-1:0] wordHere;

    logic freeFound;
    logic [idxW-1:0] freeIdx;
    logic relFound;
    logic [idxW-1:0] relIdx;

    logic accept;
    logic outFree;

    // A load stays unless a taken branch is older than it
    function automatic logic survives(
        input loadMissPkg::LdUop ld,
        input loadMissPkg::BranchProv br
    );
        logic signed [6:0] diff;
        diff = ld.sqN - br.sqN;
        return ld.external || !br.taken || (diff <= 0);
    endfunction

    always_comb begin
        full = 1'b1;
        freeFound = 1'b0;
        freeIdx = '0;
        relFound = 1'b0;
        relIdx = '0;
        for (int i = 0; i < queueSize; i++) begin
            keep[i] = survives(entries[i].ld, branch);

            // Word is in the buffer once progress has moved past its index
            wordHere[i] = loadActive && entries[i].ld.valid &&
                entries[i].ld.addr[31:lineSizeExp] == loadLine &&
                {1'b0, entries[i].ld.addr[lineSizeExp-1:2]} < loadProgress;

            if (!entries[i].ld.valid) begin
                full = 1'b0;
            end
            // Lowest free slot takes the incoming load
            if (!freeFound && !entries[i].ld.valid) begin
                freeFound = 1'b1;
                freeIdx = idxW'(i);
            end
            // Lowest ready survivor goes out first
            if (!relFound && entries[i].ld.valid && entries[i].ready && keep[i]) begin
                relFound = 1'b1;
                relIdx = idxW'(i);
            end
        end
    end

    assign accept = enqueue && newLoad.valid && freeFound && survives(newLoad, branch);
    assign outFree = !outLd.valid || dequeue;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < queueSize; i++) begin
                entries[i].ld.valid <= 1'b0;
                entries[i].ready <= 1'b0;
            end
            outLd.valid <= 1'b0;
        end else begin
            for (int i = 0; i < queueSize; i++) begin
                if (entries[i].ld.valid && !keep[i]) begin
                    entries[i].ld.valid <= 1'b0;
                end
                if (wordHere[i]) begin
                    entries[i].ready <= 1'b1;
                end
            end

            // New loads start waiting and readiness is sampled next cycle
            if (accept) begin
                entries[freeIdx].ld <= newLoad;
                entries[freeIdx].ready <= 1'b0;
            end

            if (dequeue || !survives(outLd, branch)) begin
                outLd.valid <= 1'b0;
            end
            if (relFound && outFree) begin
                outLd <= entries[relIdx].ld;
                entries[relIdx].ld.valid <= 1'b0;
            end
        end
    end

    // A load dropped while full would never return
    assert property (@(posedge clk) disable iff (rst)
        !(enqueue && newLoad.valid && full))
        else $error("enqueue while queue is full");

    // A released load always finds its word in the fill buffer
    assert property (@(posedge clk) disable iff (rst)
        outLd.valid |-> loadActive && outLd.addr[31:lineSizeExp] == loadLine &&
            {1'b0, outLd.addr[lineSizeExp-1:2]} < loadProgress)
        else $error("load released before its word arrived");

endmodule

`default_nettype wire

// File: verilog/loadMissPkg.sv
`default_nettype none

package loadMissPkg;

    // Store sequence number, wraps around
    // Age is judged by the signed difference of two values
    typedef logic [6:0] SqN;

    // Tag that identifies a load on its way back
    typedef logic [3:0] LoadId;

    // Load micro-op waiting on a cache refill
    typedef struct packed {
        logic valid;
        logic external;
        SqN sqN;
        LoadId loadId;
        // Always word aligned
        logic [31:0] addr;
    } LdUop;

    // Branch resolution as seen by the miss path
    typedef struct packed {
        logic taken;
        SqN sqN;
    } BranchProv;

    // Tagged load data returned to the core
    typedef struct packed {
        logic valid;
        LoadId loadId;
        logic [31:0] data;
    } LoadResult;

    // Refill sequencer states
    typedef enum logic {
        IDLE,
        FILLING
    } FillState;

endpackage

`default_nettype wire
